// ==== logic/spi_reg_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi register bank package
// opcode and slave state encodings, byte and register write bundles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spi_reg_pkg;

	// command byte carries a 4 bit start address in bits 3..0
	localparam int REG_ADDR_W = 4;                  // register address width

	// bit 7 of the command byte
	typedef enum logic {
		OP_READ  = 1'b0,                            // shift out stored bytes
		OP_WRITE = 1'b1                             // store received bytes
	} spi_op_e;

	// byte level slave fsm
	typedef enum logic [2:0] {
		S0_IDLE      = 3'd0,                        // load tx byte, clear rx
		S1_SCLK_IDLE = 3'd1,                        // wait for next sclk edge
		S2_SCLK_EDGE = 3'd2,                        // count the edge
		S3_LAST_HALF = 3'd3,                        // byte complete, latch rx
		S4_ACK       = 3'd4,                        // one cycle ack
		S5_FINISH    = 3'd5                         // back to idle
	} spi_state_e;

	// received byte from the slave
	typedef struct packed {
		logic       ack;                            // one cycle pulse
		logic [7:0] data;                           // held until next byte ends
	} spi_byte_t;

	// register write strobe
	typedef struct packed {
		logic                  en;                  // one cycle pulse
		logic [REG_ADDR_W-1:0] addr;                // target register
		logic [7:0]            data;                // byte to store
	} reg_wr_t;

endpackage

// ==== logic/spi_slave.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi slave, byte level
// oversamples cs/sclk/mosi on sys_clk, shifts one byte each way,
// pulses ack per full byte; cpol and cpha select the sampling edge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_slave #(
	parameter bit CPOL = 1'b1,                      // sclk idle level
	parameter bit CPHA = 1'b1                       // 0 samples on leading edge
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   cs,              // active low chip select
	input  logic                   sclk,
	input  logic                   mosi,
	input  logic [7:0]             tx_data,         // next byte to send
	output logic                   miso,
	output spi_reg_pkg::spi_byte_t rx_byte,
	output logic                   frame_start      // synced cs fall
);

	spi_reg_pkg::spi_state_e state;

	logic [2:0] cs_sync;                            // [2] is one cycle behind [1]
	logic [2:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic       cs_q;                               // cs as the fsm sees it
	logic       sclk_rise;
	logic       sclk_fall;
	logic       lead_edge;
	logic       trail_edge;
	logic       lead_pend;                          // leading edge seen outside s1
	logic       edge_hit;
	logic       sample_en;
	logic       shift_en;
	logic [3:0] cnt_sclk_edge;                      // 16 edges per byte
	logic [7:0] mosi_shift;
	logic [7:0] miso_shift;
	logic [7:0] rx_data;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_sync   <= 3'b111;                    // deselected
			sclk_sync <= {3{CPOL}};                 // idle level
		end else begin
			cs_sync   <= {cs_sync[1:0], cs};
			sclk_sync <= {sclk_sync[1:0], sclk};
		end
	end

	always_ff @(posedge sys_clk) begin
		mosi_sync <= {mosi_sync[0], mosi};          // aligned with sclk_sync[1]
	end

	// fsm runs one cycle behind the cs edge so tx_data is reloaded first
	assign cs_q        = cs_sync[2];
	assign frame_start = cs_sync[2] & ~cs_sync[1];

	assign sclk_rise  = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall  = ~sclk_sync[1] & sclk_sync[2];
	assign lead_edge  = CPOL ? sclk_fall : sclk_rise;
	assign trail_edge = CPOL ? sclk_rise : sclk_fall;

	// even counts are leading edges, odd counts trailing
	assign edge_hit = (state == spi_reg_pkg::S1_SCLK_IDLE) &&
		((~cnt_sclk_edge[0] && (lead_edge || lead_pend)) ||
		(cnt_sclk_edge[0] && trail_edge));
	assign sample_en = edge_hit && (cnt_sclk_edge[0] == CPHA);
	assign shift_en  = edge_hit && (cnt_sclk_edge[0] != CPHA) &&
		!(CPHA && (cnt_sclk_edge == 4'd0));         // bit 7 already out

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= spi_reg_pkg::S0_IDLE;
		end else if (cs_q) begin
			state <= spi_reg_pkg::S0_IDLE;          // frame end drops partial byte
		end else begin
			case (state)
				spi_reg_pkg::S0_IDLE:      state <= spi_reg_pkg::S1_SCLK_IDLE;
				spi_reg_pkg::S1_SCLK_IDLE: if (edge_hit) state <= spi_reg_pkg::S2_SCLK_EDGE;
				spi_reg_pkg::S2_SCLK_EDGE: begin
					if (cnt_sclk_edge == 4'd15)
						state <= spi_reg_pkg::S3_LAST_HALF;
					else
						state <= spi_reg_pkg::S1_SCLK_IDLE;
				end
				spi_reg_pkg::S3_LAST_HALF: state <= spi_reg_pkg::S4_ACK;
				spi_reg_pkg::S4_ACK:       state <= spi_reg_pkg::S5_FINISH;
				spi_reg_pkg::S5_FINISH:    state <= spi_reg_pkg::S0_IDLE;
				default:                   state <= spi_reg_pkg::S0_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_sclk_edge <= 4'd0;
		else if (state == spi_reg_pkg::S0_IDLE)
			cnt_sclk_edge <= 4'd0;
		else if (state == spi_reg_pkg::S2_SCLK_EDGE)
			cnt_sclk_edge <= cnt_sclk_edge + 4'd1;  // wraps after the 16th
	end

	// a back to back byte can start its leading edge during the ack tail
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n || cs_q)
			lead_pend <= 1'b0;
		else if (state == spi_reg_pkg::S1_SCLK_IDLE)
			lead_pend <= 1'b0;                      // consumed here
		else if (lead_edge)
			lead_pend <= 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			miso_shift <= 8'd0;                     // miso low out of reset
		else if (state == spi_reg_pkg::S0_IDLE && !cs_q)
			miso_shift <= tx_data;                  // msb first
		else if (shift_en)
			miso_shift <= {miso_shift[6:0], 1'b0};
	end

	always_ff @(posedge sys_clk) begin
		if (state == spi_reg_pkg::S0_IDLE)
			mosi_shift <= 8'd0;
		else if (sample_en)
			mosi_shift <= {mosi_shift[6:0], mosi_sync[1]};
	end

	always_ff @(posedge sys_clk) begin
		if (state == spi_reg_pkg::S3_LAST_HALF)
			rx_data <= mosi_shift;                  // held until next byte
	end

	assign miso    = miso_shift[7];
	assign rx_byte = '{ack: (state == spi_reg_pkg::S4_ACK), data: rx_data};

	// ack is always followed by the finish state, never a second ack
	a_ack_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_byte.ack |=> !rx_byte.ack);

	a_state_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		state inside {spi_reg_pkg::S0_IDLE, spi_reg_pkg::S1_SCLK_IDLE,
		spi_reg_pkg::S2_SCLK_EDGE, spi_reg_pkg::S3_LAST_HALF,
		spi_reg_pkg::S4_ACK, spi_reg_pkg::S5_FINISH});

endmodule

// ==== logic/spi_cmd_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi command decoder
// first byte of a frame is the command, later bytes are data with
// an auto incrementing address; feeds the slave its next tx byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_cmd_decoder (
	input  logic                                 sys_clk,
	input  logic                                 sys_rst_n,
	input  logic                                 frame_start,
	input  spi_reg_pkg::spi_byte_t               rx_byte,
	input  logic [7:0]                           rd_data,   // contents at rd_addr
	input  logic [7:0]                           wr_count,  // status byte source
	output logic [7:0]                           tx_data,
	output spi_reg_pkg::reg_wr_t                 wr,
	output logic [spi_reg_pkg::REG_ADDR_W-1:0]   rd_addr
);

	spi_reg_pkg::spi_op_e                 op;      // opcode of current frame
	logic [spi_reg_pkg::REG_ADDR_W-1:0]   addr;    // current register
	logic                                 cmd_seen; // command byte done
	logic                                 ld_tx;   // reload tx from new addr

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			op       <= spi_reg_pkg::OP_READ;
			addr     <= '0;
			cmd_seen <= 1'b0;
			ld_tx    <= 1'b0;
			wr       <= '0;
		end else begin
			ld_tx  <= 1'b0;
			wr.en  <= 1'b0;                         // single cycle strobe
			if (frame_start) begin
				cmd_seen <= 1'b0;                   // next byte is a command
			end else if (rx_byte.ack) begin
				ld_tx <= 1'b1;
				if (!cmd_seen) begin
					op       <= spi_reg_pkg::spi_op_e'(rx_byte.data[7]);
					addr     <= rx_byte.data[spi_reg_pkg::REG_ADDR_W-1:0];
					cmd_seen <= 1'b1;               // bits 6..4 ignored
				end else begin
					if (op == spi_reg_pkg::OP_WRITE)
						wr <= '{en: 1'b1, addr: addr, data: rx_byte.data};
					addr <= addr + 1'b1;            // wraps 15 -> 0
				end
			end
		end
	end

	// status byte for the command slot, then the byte at the current address
	always_ff @(posedge sys_clk) begin
		if (frame_start)
			tx_data <= wr_count;
		else if (ld_tx)
			tx_data <= rd_data;                     // addr already advanced
	end

	assign rd_addr = addr;

	// a register write needs a command byte earlier in the same frame
	a_wr_after_cmd: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wr.en |-> (cmd_seen && $past(rx_byte.ack)));

endmodule

// ==== logic/spi_reg_bank.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi register bank
// sixteen byte registers, sync write, async read, write counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_reg_bank (
	input  logic                                 sys_clk,
	input  logic                                 sys_rst_n,
	input  spi_reg_pkg::reg_wr_t                 wr,
	input  logic [spi_reg_pkg::REG_ADDR_W-1:0]   rd_addr,
	output logic [7:0]                           rd_data,
	output logic [7:0]                           wr_count    // writes since reset
);

	localparam int NUM_REGS = 2 ** spi_reg_pkg::REG_ADDR_W;

	logic [7:0] regs [NUM_REGS];

	// one register stored per write strobe
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= 8'd0;
		end else if (wr.en) begin
			regs[wr.addr] <= wr.data;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			wr_count <= 8'd0;
		else if (wr.en)
			wr_count <= wr_count + 8'd1;            // modulo 256
	end

	assign rd_data = regs[rd_addr];                 // combinational read

endmodule

// ==== logic/spi_reg_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi register bank top
// slave, command decoder and register bank behind one spi port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_reg_top #(
	parameter bit CPOL = 1'b1,                      // sclk idle level
	parameter bit CPHA = 1'b1                       // sampling edge select
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic cs,
	input  logic sclk,
	input  logic mosi,
	output logic miso
);

	spi_reg_pkg::spi_byte_t               rx_byte;
	spi_reg_pkg::reg_wr_t                 wr;
	logic                                 frame_start;
	logic [7:0]                           tx_data;
	logic [7:0]                           rd_data;
	logic [7:0]                           wr_count;
	logic [spi_reg_pkg::REG_ADDR_W-1:0]   rd_addr;

	spi_slave #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) i_spi_slave (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cs          (cs),
		.sclk        (sclk),
		.mosi        (mosi),
		.tx_data     (tx_data),
		.miso        (miso),
		.rx_byte     (rx_byte),
		.frame_start (frame_start)
	);

	spi_cmd_decoder i_spi_cmd_decoder (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.frame_start (frame_start),
		.rx_byte     (rx_byte),
		.rd_data     (rd_data),
		.wr_count    (wr_count),
		.tx_data     (tx_data),
		.wr          (wr),
		.rd_addr     (rd_addr)
	);

	spi_reg_bank i_spi_reg_bank (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr        (wr),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.wr_count  (wr_count)
	);

endmodule

// ==== sim/tb_clk_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// free running sys_clk, sys_rst_n held low for the first cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clk_gen #(
	parameter int PERIOD_NS  = 40,                  // sys_clk period
	parameter int RST_CYCLES = 5                    // rising edges in reset
) (
	output logic sys_clk,
	output logic sys_rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		sys_clk = 1'b0;
		forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;                           // sync reset, active low
		repeat (RST_CYCLES) @(posedge sys_clk);
		sys_rst_n <= 1'b1;                          // released on a rising edge
	end

endmodule

// ==== sim/tb_spi_reg_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi register bank testbench
// spi master model runs a table of read and write frames, a register
// model predicts every miso byte including the status byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_spi_reg_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int   CLK_NS   = 40;
	localparam bit   CPOL     = 1'b1;               // sclk idles high
	localparam bit   CPHA     = 1'b1;               // mosi on leading, miso on trailing
	localparam int   HALF     = 4;                  // sys_clk cycles per sclk half
	localparam logic OP_RD    = 1'b0;               // command bit 7
	localparam logic OP_WR    = 1'b1;
	localparam int   N_FRAMES = 19;

	// 5 bytes of 8 bits each, 8 cycles per bit, plus half again and reset time
	localparam int BASE_NS     = N_FRAMES * 5 * 8 * 8 * CLK_NS;
	localparam int WATCHDOG_NS = BASE_NS + BASE_NS / 2 + 10_000;

	typedef struct packed {
		logic        op;                            // read or write frame
		logic [3:0]  addr;                          // start address
		logic [2:0]  nbytes;                        // data bytes, 1..4
		logic        rnd_data;                      // data from $random
		logic        rnd_rsv;                       // random bits 6..4 of command
		logic        abort;                         // cs rises 3 bits into last byte
		logic [31:0] data;                          // byte 0 in bits 31..24
	} frame_t;

	// op, addr, nbytes, rnd_data, rnd_rsv, abort, data
	localparam frame_t FRAMES [N_FRAMES] = '{
		'{OP_RD, 4'd0,  3'd4, 1'b0, 1'b0, 1'b0, 32'h0000_0000},  // reset contents
		'{OP_RD, 4'd4,  3'd4, 1'b0, 1'b0, 1'b0, 32'h0000_0000},
		'{OP_RD, 4'd8,  3'd4, 1'b0, 1'b0, 1'b0, 32'h0000_0000},
		'{OP_RD, 4'd12, 3'd4, 1'b0, 1'b0, 1'b0, 32'h0000_0000},
		'{OP_WR, 4'd5,  3'd1, 1'b0, 1'b0, 1'b0, 32'hA500_0000},  // single write
		'{OP_RD, 4'd5,  3'd1, 1'b0, 1'b0, 1'b0, 32'h0000_0000},  // and read back
		'{OP_WR, 4'd14, 3'd4, 1'b0, 1'b0, 1'b0, 32'h1122_3344},  // wraps 15 -> 0
		'{OP_RD, 4'd14, 3'd4, 1'b0, 1'b0, 1'b0, 32'h0000_0000},
		'{OP_WR, 4'd2,  3'd3, 1'b1, 1'b0, 1'b0, 32'h0000_0000},  // random writes
		'{OP_WR, 4'd9,  3'd4, 1'b1, 1'b1, 1'b0, 32'h0000_0000},
		'{OP_WR, 4'd0,  3'd2, 1'b1, 1'b0, 1'b0, 32'h0000_0000},
		'{OP_WR, 4'd7,  3'd4, 1'b1, 1'b1, 1'b0, 32'h0000_0000},
		'{OP_RD, 4'd0,  3'd4, 1'b0, 1'b0, 1'b0, 32'h0000_0000},
		'{OP_WR, 4'd3,  3'd3, 1'b0, 1'b0, 1'b1, 32'h5A6B_7C00},  // 7c is cut short
		'{OP_RD, 4'd3,  3'd3, 1'b0, 1'b0, 1'b0, 32'h0000_0000},
		'{OP_WR, 4'd10, 3'd2, 1'b1, 1'b1, 1'b0, 32'h0000_0000},
		'{OP_RD, 4'd10, 3'd2, 1'b0, 1'b1, 1'b0, 32'hDEAD_BEEF},  // mosi ignored
		'{OP_RD, 4'd4,  3'd4, 1'b0, 1'b1, 1'b0, 32'h0000_0000},
		'{OP_RD, 4'd12, 3'd4, 1'b0, 1'b0, 1'b0, 32'h0000_0000}
	};

	logic sys_clk;
	logic sys_rst_n;
	logic cs;
	logic sclk;
	logic mosi;
	logic miso;

	logic [7:0] ref_regs [16];                      // register model
	logic [7:0] ref_count;                          // data bytes written, mod 256
	int         seed;

	tb_clk_gen #(
		.PERIOD_NS  (CLK_NS),
		.RST_CYCLES (5)
	) i_clk_gen (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	spi_reg_top #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) i_dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso)
	);

	task automatic tick(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s = 0x%02h, expected 0x%02h",
				$time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "miso byte mismatch");
		end
	endtask

	// msb first, nbits below 8 leaves a partial byte
	task automatic shift_byte(input logic [7:0] tx, input int nbits,
		output logic [7:0] rx);
		int i;
		rx = 8'd0;
		if (!CPHA)
			mosi <= tx[7];                          // set up before leading edge
		for (i = 7; i > 7 - nbits; i--) begin
			tick(HALF);
			sclk <= ~CPOL;                          // leading edge
			if (CPHA)
				mosi <= tx[i];
			else
				rx = {rx[6:0], miso};
			tick(HALF);
			sclk <= CPOL;                           // trailing edge
			if (CPHA)
				rx = {rx[6:0], miso};               // stable since the leading edge
			else if (i > 0)
				mosi <= tx[i-1];
		end
	endtask

	task automatic run_frame(input int idx, input frame_t f);
		logic [7:0] cmd;
		logic [7:0] tx;
		logic [7:0] rx;
		logic [2:0] rsv;
		logic [3:0] a;
		logic       last_cut;
		int         rnd;
		int         k;
		int         last_k;
		rsv = 3'b000;
		if (f.rnd_rsv) begin
			rnd = $random(seed);
			rsv = rnd[6:4];                         // reserved command bits
		end
		cmd    = {f.op, rsv, f.addr};
		a      = f.addr;
		last_k = int'(f.nbytes) - 1;
		tick(1);
		cs <= 1'b0;
		tick(HALF);                                 // cs setup
		shift_byte(cmd, 8, rx);
		check_value($sformatf("miso status, frame %0d", idx), rx, ref_count);
		for (k = 0; k <= last_k; k++) begin
			last_cut = f.abort && (k == last_k);
			if (f.rnd_data) begin
				rnd = $random(seed);
				tx  = rnd[7:0];
			end else begin
				tx = f.data[31 - 8*k -: 8];
			end
			tick(2 * HALF);                         // gap lets the slave reload
			shift_byte(tx, last_cut ? 3 : 8, rx);
			if (!last_cut) begin
				check_value($sformatf("miso data, frame %0d byte %0d", idx, k),
					rx, ref_regs[a]);               // old contents, also in writes
				if (f.op == OP_WR) begin
					ref_regs[a] = tx;
					ref_count   = ref_count + 8'd1;
				end
				a = a + 4'd1;                       // wraps 15 -> 0
			end
		end
		tick(2 * HALF);                             // last ack and write land first
		cs <= 1'b1;
		tick(2 * HALF);                             // idle between frames
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: frame table did not finish within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int n;
		cs        = 1'b1;                           // deselected
		sclk      = CPOL;                           // idle level
		mosi      = 1'b0;
		seed      = 37;
		ref_count = 8'd0;
		for (n = 0; n < 16; n++)
			ref_regs[n] = 8'd0;
		wait (sys_rst_n === 1'b1);
		tick(4);
		for (n = 0; n < N_FRAMES; n++)
			run_frame(n, FRAMES[n]);
		tick(4);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== spi_reg_top.f ====
logic/spi_reg_pkg.sv
logic/spi_slave.sv
logic/spi_cmd_decoder.sv
logic/spi_reg_bank.sv
logic/spi_reg_top.sv
sim/tb_clk_gen.sv
sim/tb_spi_reg_top.sv

// ==== Makefile ====
# Verilator build and run of the SPI register bank testbench

TOP = tb_spi_reg_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f spi_reg_top.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^ALL TESTS PASSED$$"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module spi_reg_top -f spi_reg_top.f

clean:
	rm -rf obj_dir
